// ==== design/raster_pkg.sv ====
package raster_pkg;

  // counter widths
  localparam int hcount_w = 7;
  localparam int vcount_w = 6;

  // horizontal timing in pixels
  // back porch is whatever remains of h_total
  localparam logic [hcount_w-1:0] h_active = 64;
  localparam logic [hcount_w-1:0] h_front = 4;
  localparam logic [hcount_w-1:0] h_sync = 8;
  localparam logic [hcount_w-1:0] h_total = 80;

  // vertical timing in lines
  localparam logic [vcount_w-1:0] v_active = 48;
  localparam logic [vcount_w-1:0] v_front = 2;
  localparam logic [vcount_w-1:0] v_sync = 3;
  localparam logic [vcount_w-1:0] v_total = 56;

  // render region, half-open, inside the active area
  localparam logic [hcount_w-1:0] start_x = 16;
  localparam logic [hcount_w-1:0] end_x = 48;
  localparam logic [vcount_w-1:0] start_y = 8;
  localparam logic [vcount_w-1:0] end_y = 40;
  localparam int region_w = int'(end_x - start_x);
  localparam int region_h = int'(end_y - start_y);
  localparam int fb_depth = region_w * region_h;
  localparam int fb_addr_w = $clog2(fb_depth);

  // one screen position
  typedef struct packed {
    logic [hcount_w-1:0] x;
    logic [vcount_w-1:0] y;
  } coord_t;

  // 4 bits per channel
  typedef struct packed {
    logic [3:0] r;
    logic [3:0] g;
    logic [3:0] b;
  } rgb12_t;

  // shader result, colour plus where it goes
  typedef struct packed {
    coord_t pos;
    rgb12_t color;
  } shaded_t;

  // display control bits, syncs active low
  typedef struct packed {
    logic hsync;
    logic vsync;
    logic active;
    logic in_region;
  } vid_ctrl_t;

  // disc and checkerboard scene
  localparam logic [hcount_w-1:0] disc_cx = 32;
  localparam logic [vcount_w-1:0] disc_cy = 24;
  // radius 12, squared
  localparam logic [15:0] disc_r2 = 144;
  localparam rgb12_t disc_color = 12'hf80;
  localparam rgb12_t check_dark = 12'h222;
  localparam rgb12_t check_light = 12'h555;

  // pipeline latencies in cycles
  localparam int shade_latency = 3;
  localparam int read_latency = 2;

endpackage

// ==== design/video_timing.sv ====
`timescale 1ns/1ps
`default_nettype none

module video_timing (
  input  logic                  clk_pixel,
  input  logic                  rst_n,
  output raster_pkg::coord_t    pos,
  output raster_pkg::vid_ctrl_t ctrl,
  output logic                  new_frame
);

  logic [raster_pkg::hcount_w-1:0] hcount;
  logic [raster_pkg::vcount_w-1:0] vcount;
  logic line_end;
  logic frame_end;

  // last pixel of a line and last line of a frame
  assign line_end = hcount == raster_pkg::h_total - 1'b1;
  assign frame_end = vcount == raster_pkg::v_total - 1'b1;

  // nested counters with vcount stepping once per line
  always_ff @(posedge clk_pixel or negedge rst_n) begin
    if (!rst_n) begin
      hcount <= '0;
      vcount <= '0;
    end else if (line_end) begin
      hcount <= '0;
      vcount <= frame_end ? '0 : vcount + 1'b1;
    end else begin
      hcount <= hcount + 1'b1;
    end
  end

  assign pos.x = hcount;
  assign pos.y = vcount;

  // sync pulses start right after the front porch
  assign ctrl.hsync = !(hcount >= raster_pkg::h_active + raster_pkg::h_front &&
                        hcount < raster_pkg::h_active + raster_pkg::h_front +
                                 raster_pkg::h_sync);
  assign ctrl.vsync = !(vcount >= raster_pkg::v_active + raster_pkg::v_front &&
                        vcount < raster_pkg::v_active + raster_pkg::v_front +
                                 raster_pkg::v_sync);

  // visible area
  assign ctrl.active = hcount < raster_pkg::h_active && vcount < raster_pkg::v_active;

  // inside the rendered rectangle
  assign ctrl.in_region = hcount >= raster_pkg::start_x && hcount < raster_pkg::end_x &&
                          vcount >= raster_pkg::start_y && vcount < raster_pkg::end_y;

  // single pulse at the top left corner
  assign new_frame = hcount == '0 && vcount == '0;

  // line counter must wrap before h_total
  a_hcount_range: assert property (@(posedge clk_pixel) disable iff (!rst_n)
    hcount < raster_pkg::h_total)
    else $error("hcount out of range");

endmodule

`default_nettype wire

// ==== design/region_scan.sv ====
`timescale 1ns/1ps
`default_nettype none

module region_scan (
  input  logic               clk_pixel,
  input  logic               rst_n,
  output raster_pkg::coord_t pos
);

  logic [raster_pkg::hcount_w-1:0] x;
  logic [raster_pkg::vcount_w-1:0] y;

  // raster walk over the region, one pixel per cycle
  always_ff @(posedge clk_pixel or negedge rst_n) begin
    if (!rst_n) begin
      x <= raster_pkg::start_x;
      y <= raster_pkg::start_y;
    end else if (x == raster_pkg::end_x - 1'b1) begin
      // end of a region row
      x <= raster_pkg::start_x;
      if (y == raster_pkg::end_y - 1'b1) begin
        // whole pass done, back to the start corner
        y <= raster_pkg::start_y;
      end else begin
        y <= y + 1'b1;
      end
    end else begin
      x <= x + 1'b1;
    end
  end

  assign pos.x = x;
  assign pos.y = y;

  // shader and buffer addressing rely on this
  a_in_region: assert property (@(posedge clk_pixel) disable iff (!rst_n)
    pos.x >= raster_pkg::start_x && pos.x < raster_pkg::end_x &&
    pos.y >= raster_pkg::start_y && pos.y < raster_pkg::end_y)
    else $error("scan left the render region");

endmodule

`default_nettype wire

// ==== design/disc_shader.sv ====
`timescale 1ns/1ps
`default_nettype none

module disc_shader (
  input  logic                clk_pixel,
  input  logic                rst_n,
  input  raster_pkg::coord_t  pos,
  output raster_pkg::shaded_t pix,
  output logic                valid
);

  // stage 1, signed offsets from the disc centre
  raster_pkg::coord_t s1_pos;
  logic signed [raster_pkg::hcount_w:0] dx;
  logic signed [raster_pkg::vcount_w:0] dy;

  // stage 2, squared distance
  raster_pkg::coord_t s2_pos;
  logic signed [15:0] sq_x;
  logic signed [15:0] sq_y;
  logic [15:0] sum_sq;

  // one bit per stage, fills with ones after reset
  logic [raster_pkg::shade_latency-1:0] vld_sr;

  // squares never go negative
  assign sq_x = dx * dx;
  assign sq_y = dy * dy;

  always_ff @(posedge clk_pixel) begin
    s1_pos <= pos;
    dx <= $signed({1'b0, pos.x}) - $signed({1'b0, raster_pkg::disc_cx});
    dy <= $signed({1'b0, pos.y}) - $signed({1'b0, raster_pkg::disc_cy});

    s2_pos <= s1_pos;
    sum_sq <= sq_x + sq_y;

    // stage 3, pick the colour
    pix.pos <= s2_pos;
    if (sum_sq < raster_pkg::disc_r2) begin
      pix.color <= raster_pkg::disc_color;
    end else if (s2_pos.x[2] != s2_pos.y[2]) begin
      // 4x4 checker cells
      pix.color <= raster_pkg::check_light;
    end else begin
      pix.color <= raster_pkg::check_dark;
    end
  end

  // walker never stalls, so valid just trails reset by the latency
  always_ff @(posedge clk_pixel or negedge rst_n) begin
    if (!rst_n) begin
      vld_sr <= '0;
    end else begin
      vld_sr <= {vld_sr[raster_pkg::shade_latency-2:0], 1'b1};
    end
  end

  assign valid = vld_sr[raster_pkg::shade_latency-1];

endmodule

`default_nettype wire

// ==== design/frame_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_buffer (
  input  logic                clk_pixel,
  input  logic                rst_n,
  input  raster_pkg::shaded_t wr,
  input  logic                we,
  input  raster_pkg::coord_t  rd_pos,
  input  logic                rd_region,
  output raster_pkg::rgb12_t  rd_data
);

  typedef logic [raster_pkg::fb_addr_w-1:0] addr_t;

  // region-relative address, row major
  function automatic addr_t addr_of(input raster_pkg::coord_t p);
    addr_t col;
    addr_t row;
    col = addr_t'(p.x - raster_pkg::start_x);
    row = addr_t'(p.y - raster_pkg::start_y);
    return col + row * addr_t'(raster_pkg::region_w);
  endfunction

  raster_pkg::rgb12_t mem [raster_pkg::fb_depth];
  addr_t wr_addr;
  addr_t rd_addr_q;

  assign wr_addr = addr_of(wr.pos);

  // write port, shader side
  always_ff @(posedge clk_pixel) begin
    if (we) begin
      mem[wr_addr] <= wr.color;
    end
  end

  // read port, address register then output register
  // outside the region the address parks at 0
  always_ff @(posedge clk_pixel or negedge rst_n) begin
    if (!rst_n) begin
      rd_addr_q <= '0;
      rd_data <= '0;
    end else begin
      rd_addr_q <= rd_region ? addr_of(rd_pos) : '0;
      rd_data <= mem[rd_addr_q];
    end
  end

  // address only stays below fb_depth for in-region writes
  a_wr_addr: assert property (@(posedge clk_pixel) disable iff (!rst_n)
    we |-> wr.pos.x >= raster_pkg::start_x && wr.pos.x < raster_pkg::end_x &&
           wr.pos.y >= raster_pkg::start_y && wr.pos.y < raster_pkg::end_y)
    else $error("write outside the frame buffer");

endmodule

`default_nettype wire

// ==== design/sync_delay.sv ====
`timescale 1ns/1ps
`default_nettype none

module sync_delay (
  input  logic                  clk_pixel,
  input  logic                  rst_n,
  input  raster_pkg::vid_ctrl_t ctrl_in,
  output raster_pkg::vid_ctrl_t ctrl_out
);

  // one stage per cycle of buffer read latency
  raster_pkg::vid_ctrl_t pipe [raster_pkg::read_latency];

  always_ff @(posedge clk_pixel or negedge rst_n) begin
    if (!rst_n) begin
      // idle: syncs released, nothing drawn
      for (int i = 0; i < raster_pkg::read_latency; i++) begin
        pipe[i] <= '{hsync: 1'b1, vsync: 1'b1, active: 1'b0, in_region: 1'b0};
      end
    end else begin
      pipe[0] <= ctrl_in;
      for (int i = 1; i < raster_pkg::read_latency; i++) begin
        pipe[i] <= pipe[i-1];
      end
    end
  end

  assign ctrl_out = pipe[raster_pkg::read_latency-1];

endmodule

`default_nettype wire

// ==== design/pixel_count_display.sv ====
`timescale 1ns/1ps
`default_nettype none

module pixel_count_display (
  input  logic       clk_pixel,
  input  logic       rst_n,
  input  logic       evt,
  output logic [6:0] cat,
  output logic [7:0] an
);

  logic [31:0] count;
  // cycles spent on the current digit
  logic [2:0] tick;
  logic [2:0] digit;
  logic [3:0] nibble;

  // active-low segments, bit 0 is segment a
  function automatic logic [6:0] glyph(input logic [3:0] val);
    logic [6:0] seg;
    case (val)
      4'h0: seg = 7'h3f;
      4'h1: seg = 7'h06;
      4'h2: seg = 7'h5b;
      4'h3: seg = 7'h4f;
      4'h4: seg = 7'h66;
      4'h5: seg = 7'h6d;
      4'h6: seg = 7'h7d;
      4'h7: seg = 7'h07;
      4'h8: seg = 7'h7f;
      4'h9: seg = 7'h6f;
      4'ha: seg = 7'h77;
      4'hb: seg = 7'h7c;
      4'hc: seg = 7'h39;
      4'hd: seg = 7'h5e;
      4'he: seg = 7'h79;
      default: seg = 7'h71;
    endcase
    return ~seg;
  endfunction

  // event counter, free running
  always_ff @(posedge clk_pixel or negedge rst_n) begin
    if (!rst_n) begin
      count <= '0;
    end else if (evt) begin
      count <= count + 1'b1;
    end
  end

  // nibble for the digit being lit
  assign nibble = count[digit*4 +: 4];

  // scan, next digit every 8 cycles
  // an and cat register together so they always agree
  always_ff @(posedge clk_pixel or negedge rst_n) begin
    if (!rst_n) begin
      tick <= '0;
      digit <= '0;
      an <= 8'hff;
      cat <= glyph(4'h0);
    end else begin
      tick <= tick + 1'b1;
      if (&tick) begin
        digit <= digit + 1'b1;
      end
      an <= ~(8'b1 << digit);
      cat <= glyph(nibble);
    end
  end

  // never two digits lit at once
  a_one_anode: assert property (@(posedge clk_pixel) disable iff (!rst_n)
    $countones(~an) <= 1)
    else $error("more than one anode low");

endmodule

`default_nettype wire

// ==== design/raster_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module raster_top (
  input  logic       clk_pixel,
  input  logic       rst_n,
  output logic [3:0] vga_r,
  output logic [3:0] vga_g,
  output logic [3:0] vga_b,
  output logic       vga_hs,
  output logic       vga_vs,
  output logic [6:0] cat,
  output logic [7:0] an
);

  // display side
  raster_pkg::coord_t disp_pos;
  raster_pkg::vid_ctrl_t disp_ctrl;
  logic new_frame;

  // render side
  raster_pkg::coord_t scan_pos;
  raster_pkg::shaded_t shade_pix;
  logic shade_valid;

  // after the buffer read latency
  raster_pkg::rgb12_t fb_data;
  raster_pkg::vid_ctrl_t ctrl_d;
  logic show;

  video_timing u_timing (
    .clk_pixel(clk_pixel),
    .rst_n(rst_n),
    .pos(disp_pos),
    .ctrl(disp_ctrl),
    .new_frame(new_frame)
  );

  region_scan u_scan (
    .clk_pixel(clk_pixel),
    .rst_n(rst_n),
    .pos(scan_pos)
  );

  disc_shader u_shader (
    .clk_pixel(clk_pixel),
    .rst_n(rst_n),
    .pos(scan_pos),
    .pix(shade_pix),
    .valid(shade_valid)
  );

  // shader writes while the display reads on the same clock
  frame_buffer u_fb (
    .clk_pixel(clk_pixel),
    .rst_n(rst_n),
    .wr(shade_pix),
    .we(shade_valid),
    .rd_pos(disp_pos),
    .rd_region(disp_ctrl.in_region),
    .rd_data(fb_data)
  );

  // control bits follow the read data
  sync_delay u_sync (
    .clk_pixel(clk_pixel),
    .rst_n(rst_n),
    .ctrl_in(disp_ctrl),
    .ctrl_out(ctrl_d)
  );

  pixel_count_display u_count (
    .clk_pixel(clk_pixel),
    .rst_n(rst_n),
    .evt(shade_valid),
    .cat(cat),
    .an(an)
  );

  // black outside the drawn region
  assign show = ctrl_d.active && ctrl_d.in_region;
  assign vga_r = show ? fb_data.r : 4'h0;
  assign vga_g = show ? fb_data.g : 4'h0;
  assign vga_b = show ? fb_data.b : 4'h0;
  assign vga_hs = ctrl_d.hsync;
  assign vga_vs = ctrl_d.vsync;

  // first visible pixel of a frame reaches the pins exactly read_latency cycles later
  a_frame_align: assert property (@(posedge clk_pixel) disable iff (!rst_n)
    new_frame |-> ##(raster_pkg::read_latency)
      ($rose(ctrl_d.active) && !ctrl_d.in_region && vga_hs && vga_vs))
    else $error("display control not aligned with frame start");

endmodule

`default_nettype wire

// ==== tb/raster_tb.sv ====
`timescale 1ns/1ps

module raster_tb;

  logic clk_pixel;
  logic rst_n;
  logic [3:0] vga_r;
  logic [3:0] vga_g;
  logic [3:0] vga_b;
  logic vga_hs;
  logic vga_vs;
  logic [6:0] cat;
  logic [7:0] an;

  // screen position of the pixel now on the outputs, rebuilt from the syncs
  int tx;
  int ty;
  logic h_locked;
  logic v_locked;
  // frame starts seen since vertical lock
  int frames;
  // negedges since reset release, saturating
  int since_rst = 0;
  logic primed = 1'b0;
  logic hs_q;
  logic vs_q;
  int err_count = 0;
  logic [31:0] lfsr_state;

  logic [11:0] rgb;
  logic exp_hs;
  logic exp_vs;
  logic in_act;
  logic in_reg;
  logic [11:0] exp_rgb;
  logic glyph_ok;
  logic one_digit;

  raster_top u_dut (
    .clk_pixel(clk_pixel),
    .rst_n(rst_n),
    .vga_r(vga_r),
    .vga_g(vga_g),
    .vga_b(vga_b),
    .vga_hs(vga_hs),
    .vga_vs(vga_vs),
    .cat(cat),
    .an(an)
  );

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic draw_bits(input int n, output int val);
    val = 0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      val = (val << 1) | int'(lfsr_state[0]);
    end
  endtask

  // disc over a 4x4 checkerboard
  function automatic logic [11:0] scene_color(input int x, input int y);
    int dx;
    int dy;
    dx = x - int'(raster_pkg::disc_cx);
    dy = y - int'(raster_pkg::disc_cy);
    if (dx * dx + dy * dy < int'(raster_pkg::disc_r2)) begin
      return raster_pkg::disc_color;
    end else if (x[2] != y[2]) begin
      return raster_pkg::check_light;
    end
    return raster_pkg::check_dark;
  endfunction

  // active-low a..g patterns of 0..f
  function automatic logic is_hex_glyph(input logic [6:0] seg);
    case (seg)
      7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
      7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0e: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  task automatic stop_run(input string line);
    err_count++;
    $display("%s", line);
    $display("Test failures found");
    $fatal(1, "run stopped at first error");
  endtask

  initial begin
    clk_pixel = 1'b0;
    // 4 ns period
    forever #2 clk_pixel = ~clk_pixel;
  end

  // follow the outputs mid-cycle, where they are settled
  always @(negedge clk_pixel) begin
    int nx;
    int ny;
    primed <= 1'b1;
    if (!rst_n) begin
      h_locked <= 1'b0;
      v_locked <= 1'b0;
      frames <= 0;
      tx <= 0;
      ty <= 0;
      hs_q <= 1'b1;
      vs_q <= 1'b1;
      since_rst <= 0;
    end else begin
      nx = (tx + 1) % int'(raster_pkg::h_total);
      // first hsync fall is the first pixel of the sync pulse
      if (!h_locked && hs_q && !vga_hs) begin
        nx = int'(raster_pkg::h_active) + int'(raster_pkg::h_front);
        h_locked <= 1'b1;
      end
      ny = ty;
      if (nx == 0) begin
        ny = (ty + 1) % int'(raster_pkg::v_total);
      end
      // vsync falls at x 0 of the first sync line
      if (!v_locked && vs_q && !vga_vs) begin
        ny = int'(raster_pkg::v_active) + int'(raster_pkg::v_front);
        v_locked <= 1'b1;
      end
      if (v_locked && nx == 0 && ny == 0) begin
        frames <= frames + 1;
      end
      tx <= nx;
      ty <= ny;
      hs_q <= vga_hs;
      vs_q <= vga_vs;
      if (since_rst < 16) begin
        since_rst <= since_rst + 1;
      end
    end
  end

  assign rgb = {vga_r, vga_g, vga_b};
  assign exp_hs = !(tx >= int'(raster_pkg::h_active + raster_pkg::h_front) &&
                    tx < int'(raster_pkg::h_active + raster_pkg::h_front + raster_pkg::h_sync));
  assign exp_vs = !(ty >= int'(raster_pkg::v_active + raster_pkg::v_front) &&
                    ty < int'(raster_pkg::v_active + raster_pkg::v_front + raster_pkg::v_sync));
  assign in_act = tx < int'(raster_pkg::h_active) && ty < int'(raster_pkg::v_active);
  assign in_reg = tx >= int'(raster_pkg::start_x) && tx < int'(raster_pkg::end_x) &&
                  ty >= int'(raster_pkg::start_y) && ty < int'(raster_pkg::end_y);
  assign exp_rgb = (in_act && in_reg) ? scene_color(tx, ty) : 12'h000;
  assign glyph_ok = is_hex_glyph(cat);
  assign one_digit = $onehot(~an);

  // sync pulse width and period against the free-running position
  a_hsync: assert property (@(posedge clk_pixel) rst_n && h_locked |-> vga_hs == exp_hs)
    else stop_run($sformatf("[FAIL] %0t hsync %0b expected %0b at x %0d",
                            $time, $sampled(vga_hs), $sampled(exp_hs), $sampled(tx)));

  a_vsync: assert property (@(posedge clk_pixel) rst_n && v_locked |-> vga_vs == exp_vs)
    else stop_run($sformatf("[FAIL] %0t vsync %0b expected %0b at y %0d",
                            $time, $sampled(vga_vs), $sampled(exp_vs), $sampled(ty)));

  a_blank: assert property (@(posedge clk_pixel)
    rst_n && v_locked && !(in_act && in_reg) |-> rgb == 12'h000)
    else stop_run($sformatf("[FAIL] %0t colour %h outside region at (%0d,%0d)",
                            $time, $sampled(rgb), $sampled(tx), $sampled(ty)));

  // buffer is full by the first whole frame after lock
  a_image: assert property (@(posedge clk_pixel)
    rst_n && v_locked && frames >= 1 && in_act && in_reg |-> rgb == exp_rgb)
    else stop_run($sformatf("[FAIL] %0t colour %h expected %h at (%0d,%0d)", $time,
                            $sampled(rgb), $sampled(exp_rgb), $sampled(tx), $sampled(ty)));

  a_anode: assert property (@(posedge clk_pixel) rst_n && since_rst >= 2 |-> one_digit)
    else stop_run($sformatf("[FAIL] %0t anodes %b not one digit", $time, $sampled(an)));

  a_glyph: assert property (@(posedge clk_pixel) rst_n && since_rst >= 2 |-> glyph_ok)
    else stop_run($sformatf("[FAIL] %0t segments %h not a hex glyph", $time, $sampled(cat)));

  // idle outputs in reset and while the pipe refills
  a_reset_idle: assert property (@(posedge clk_pixel)
    primed && (!rst_n || since_rst < 3) |-> vga_hs && vga_vs && rgb == 12'h000)
    else stop_run($sformatf("[FAIL] %0t outputs not idle around reset hs %0b vs %0b rgb %h",
                            $time, $sampled(vga_hs), $sampled(vga_vs), $sampled(rgb)));

  initial begin
    int extra_wait;
    lfsr_state = 32'hbcc3_a7c2;
    rst_n = 1'b0;
    repeat (5) @(posedge clk_pixel);
    #1 rst_n = 1'b1;
    // lock, then one checked frame
    while (frames < 2) begin
      @(posedge clk_pixel);
    end
    // extra reset somewhere in the next 4096 cycles
    draw_bits(12, extra_wait);
    repeat (extra_wait) @(posedge clk_pixel);
    #1 rst_n = 1'b0;
    repeat (5) @(posedge clk_pixel);
    #1 rst_n = 1'b1;
    // relock, then two checked frames
    while (frames < 3) begin
      @(posedge clk_pixel);
    end
    if (err_count == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  initial begin
    int frame_ns;
    frame_ns = int'(raster_pkg::h_total) * int'(raster_pkg::v_total) * 4;
    // about 3 frames before the extra reset, under 1 of random wait,
    // 4 after it, plus slack
    #(frame_ns * 10);
    stop_run("watchdog expired before the run completed");
  end

endmodule

// ==== src.f ====
design/raster_pkg.sv
design/video_timing.sv
design/region_scan.sv
design/disc_shader.sv
design/frame_buffer.sv
design/sync_delay.sv
design/pixel_count_display.sv
design/raster_top.sv
tb/raster_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the raster testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f src.f --top-module raster_tb

# the simulator exits nonzero on $fatal, keep its output for the search
out=$(./obj_dir/Vraster_tb) || true
echo "$out"

if echo "$out" | grep -q "All tests passed!"; then
  exit 0
else
  exit 1
fi
